// File: conv_pkg.sv
package conv_pkg;

  // kernel geometry
  localparam int WT_DIM  = 5;
  localparam int WT_SIZE = WT_DIM * WT_DIM;

  // bus and datapath widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ACC_W  = 32;
  localparam int PROD_W = 16;

  // accumulator scaling before write-back
  localparam int OUT_SHIFT = 9;

  localparam int OFM_BYTES = 4;

  typedef logic signed [7:0]        pixel_t;
  typedef logic signed [7:0]        weight_t;
  typedef logic [ADDR_W-1:0]        addr_t;
  typedef logic [DATA_W-1:0]        word_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_FETCH_WT,
    PH_FETCH_IFM,
    PH_COMPUTE,
    PH_WRITE_REQ,
    PH_WRITE_DATA,
    PH_DONE
  } phase_e;

endpackage

// File: win_if.sv
`timescale 1ns/10ps

interface win_if #(
  parameter type elem_t = conv_pkg::pixel_t
) ();

  // single-cycle strobes with at most one high per cycle
  logic  clear;
  logic  load;
  logic  rotate;
  elem_t din;
  elem_t head;

  modport ctrl (output clear, load, rotate, din, input head);
  modport buffer (input clear, load, rotate, din, output head);
  modport mac (input head);

endinterface

// File: window_buffer.sv
`timescale 1ns/10ps

module window_buffer #(
  parameter type elem_t = conv_pkg::pixel_t
) (
  input logic   clk,
  input logic   rst,
  win_if.buffer win
);

  elem_t entries [conv_pkg::WT_SIZE];

  // loads enter at the tail, rotation moves the head back to the tail
  always_ff @(posedge clk) begin
    if (rst || win.clear) begin
      for (int i = 0; i < conv_pkg::WT_SIZE; i++) begin
        entries[i] <= '0;
      end
    end else if (win.load || win.rotate) begin
      for (int i = 0; i < conv_pkg::WT_SIZE - 1; i++) begin
        entries[i] <= entries[i+1];
      end
      entries[conv_pkg::WT_SIZE-1] <= win.load ? win.din : entries[0];
    end
  end

  assign win.head = entries[0];

  // the controller never fetches and computes in the same cycle
  load_rotate_excl: assert property (
    @(posedge clk) disable iff (rst) !(win.load && win.rotate)
  );

endmodule

// File: mac_unit.sv
`timescale 1ns/10ps

module mac_unit (
  input  logic              clk,
  input  logic              rst,
  input  logic              mac_clear,
  input  logic              mac_en,
  input  conv_pkg::pixel_t  pixel,
  input  conv_pkg::weight_t weight,
  output conv_pkg::word_t   result
);

  logic signed [conv_pkg::PROD_W-1:0] product;
  conv_pkg::acc_t                     product_ext;
  conv_pkg::acc_t                     acc;

  assign product = pixel * weight;

  // sign extend the 16-bit product into the accumulator width
  assign product_ext = {{(conv_pkg::ACC_W - conv_pkg::PROD_W){product[conv_pkg::PROD_W-1]}},
                        product};

  always_ff @(posedge clk) begin
    if (rst || mac_clear) begin
      acc <= '0;
    end else if (mac_en) begin
      acc <= acc + product_ext;
    end
  end

  // arithmetic shift keeps the sign of negative sums
  assign result = conv_pkg::word_t'(acc >>> conv_pkg::OUT_SHIFT);

  // clearing only happens on entry to a window fetch and never mid-compute
  clear_en_excl: assert property (
    @(posedge clk) disable iff (rst) !(mac_clear && mac_en)
  );

endmodule

// File: conv_ctrl.sv
`timescale 1ns/10ps

module conv_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              xcel_start,
  output logic              xcel_done,
  output logic              xcel_idle,
  input  conv_pkg::addr_t   ifm_ddr_addr,
  input  conv_pkg::addr_t   wt_ddr_addr,
  input  conv_pkg::addr_t   ofm_ddr_addr,
  input  logic [31:0]       ifm_dim,
  output logic              read_req_valid,
  input  logic              read_req_ready,
  output conv_pkg::addr_t   read_addr,
  input  conv_pkg::word_t   read_data,
  input  logic              read_data_valid,
  output logic              read_data_ready,
  output logic              write_req_valid,
  input  logic              write_req_ready,
  output conv_pkg::addr_t   write_addr,
  output conv_pkg::word_t   write_data,
  output logic              write_data_valid,
  input  logic              write_data_ready,
  win_if.ctrl               wt_win,
  win_if.ctrl               ifm_win,
  output logic              mac_clear,
  output logic              mac_en,
  input  conv_pkg::word_t   mac_result
);

  conv_pkg::phase_e phase, phase_next;

  logic [2:0]      wx, wy;
  logic [31:0]     ox, oy;
  logic [4:0]      comp_cnt;
  logic            rd_pending;
  logic            done_q;
  logic [31:0]     ofm_dim;
  logic            in_wt, in_ifm, in_compute;
  logic            start_fire, rd_req_fire, rd_data_fire, wr_req_fire, wr_data_fire;
  logic            win_last, pix_last, comp_last, enter_ifm;
  conv_pkg::addr_t wt_addr, ifm_addr, ofm_addr;
  logic [7:0]      rd_byte;

  assign ofm_dim = ifm_dim - (conv_pkg::WT_DIM - 1);

  assign in_wt      = phase == conv_pkg::PH_FETCH_WT;
  assign in_ifm     = phase == conv_pkg::PH_FETCH_IFM;
  assign in_compute = phase == conv_pkg::PH_COMPUTE;

  assign start_fire   = (phase == conv_pkg::PH_IDLE) && xcel_start;
  assign rd_req_fire  = read_req_valid && read_req_ready;
  assign rd_data_fire = read_data_valid && read_data_ready;
  assign wr_req_fire  = write_req_valid && write_req_ready;
  assign wr_data_fire = write_data_valid && write_data_ready;

  assign win_last  = (wx == conv_pkg::WT_DIM - 1) && (wy == conv_pkg::WT_DIM - 1);
  assign pix_last  = (ox == ofm_dim - 1) && (oy == ofm_dim - 1);
  assign comp_last = comp_cnt == conv_pkg::WT_SIZE - 1;
  assign enter_ifm = (in_wt && rd_data_fire && win_last) ||
                     (phase == conv_pkg::PH_WRITE_DATA && wr_data_fire && !pix_last);

  always_comb begin
    phase_next = phase;
    case (phase)
      conv_pkg::PH_IDLE:       if (xcel_start) phase_next = conv_pkg::PH_FETCH_WT;
      conv_pkg::PH_FETCH_WT:   if (rd_data_fire && win_last) phase_next = conv_pkg::PH_FETCH_IFM;
      conv_pkg::PH_FETCH_IFM:  if (rd_data_fire && win_last) phase_next = conv_pkg::PH_COMPUTE;
      conv_pkg::PH_COMPUTE:    if (comp_last) phase_next = conv_pkg::PH_WRITE_REQ;
      conv_pkg::PH_WRITE_REQ:  if (wr_req_fire) phase_next = conv_pkg::PH_WRITE_DATA;
      conv_pkg::PH_WRITE_DATA: begin
        if (wr_data_fire) begin
          phase_next = pix_last ? conv_pkg::PH_DONE : conv_pkg::PH_FETCH_IFM;
        end
      end
      default:                 phase_next = conv_pkg::PH_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase      <= conv_pkg::PH_IDLE;
      rd_pending <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      phase <= phase_next;
      if (rd_req_fire) begin
        rd_pending <= 1'b1;
      end else if (rd_data_fire) begin
        rd_pending <= 1'b0;
      end
      if (start_fire) begin
        done_q <= 1'b0;
      end else if (phase == conv_pkg::PH_DONE) begin
        done_q <= 1'b1;
      end
    end
  end

  // window counters with wx as the inner loop
  always_ff @(posedge clk) begin
    if (rst) begin
      wx <= '0;
      wy <= '0;
    end else if (rd_data_fire) begin
      if (wx == conv_pkg::WT_DIM - 1) begin
        wx <= '0;
        wy <= (wy == conv_pkg::WT_DIM - 1) ? 3'd0 : wy + 3'd1;
      end else begin
        wx <= wx + 3'd1;
      end
    end
  end

  // output pixel counters advance on each write-data fire
  always_ff @(posedge clk) begin
    if (rst || start_fire) begin
      ox <= '0;
      oy <= '0;
    end else if (wr_data_fire) begin
      if (ox == ofm_dim - 1) begin
        ox <= '0;
        oy <= pix_last ? 32'd0 : oy + 32'd1;
      end else begin
        ox <= ox + 32'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || !in_compute) begin
      comp_cnt <= '0;
    end else begin
      comp_cnt <= comp_cnt + 5'd1;
    end
  end

  assign wt_addr  = wt_ddr_addr + wy * conv_pkg::WT_DIM + wx;
  assign ifm_addr = ifm_ddr_addr + (oy + wy) * ifm_dim + ox + wx;
  assign ofm_addr = ofm_ddr_addr + conv_pkg::OFM_BYTES * (oy * ofm_dim + ox);

  // the memory returns the aligned word
  assign rd_byte = read_data[8*read_addr[1:0] +: 8];

  assign read_req_valid  = (in_wt || in_ifm) && !rd_pending;
  assign read_data_ready = (in_wt || in_ifm) && rd_pending;
  assign read_addr       = in_wt ? wt_addr : ifm_addr;

  assign write_req_valid  = phase == conv_pkg::PH_WRITE_REQ;
  assign write_data_valid = phase == conv_pkg::PH_WRITE_DATA;
  assign write_addr       = ofm_addr;
  assign write_data       = mac_result;

  assign wt_win.clear  = start_fire;
  assign wt_win.load   = in_wt && rd_data_fire;
  assign wt_win.rotate = in_compute;
  assign wt_win.din    = rd_byte;

  assign ifm_win.clear  = start_fire;
  assign ifm_win.load   = in_ifm && rd_data_fire;
  assign ifm_win.rotate = in_compute;
  assign ifm_win.din    = rd_byte;

  assign mac_clear = enter_ifm;
  assign mac_en    = in_compute;

  assign xcel_idle = phase == conv_pkg::PH_IDLE;
  assign xcel_done = done_q && !xcel_start;

  rd_req_hold: assert property (
    @(posedge clk) disable iff (rst)
    read_req_valid && !read_req_ready |=> read_req_valid && $stable(read_addr)
  );

  wr_req_hold: assert property (
    @(posedge clk) disable iff (rst)
    write_req_valid && !write_req_ready |=> write_req_valid && $stable(write_addr)
  );

endmodule

// File: conv_xcel.sv
`timescale 1ns/10ps

module conv_xcel (
  input  logic            clk,
  input  logic            rst,
  input  logic            xcel_start,
  output logic            xcel_done,
  output logic            xcel_idle,
  input  conv_pkg::addr_t ifm_ddr_addr,
  input  conv_pkg::addr_t wt_ddr_addr,
  input  conv_pkg::addr_t ofm_ddr_addr,
  input  logic [31:0]     ifm_dim,
  output logic            read_req_valid,
  input  logic            read_req_ready,
  output conv_pkg::addr_t read_addr,
  input  conv_pkg::word_t read_data,
  input  logic            read_data_valid,
  output logic            read_data_ready,
  output logic            write_req_valid,
  input  logic            write_req_ready,
  output conv_pkg::addr_t write_addr,
  output conv_pkg::word_t write_data,
  output logic            write_data_valid,
  input  logic            write_data_ready
);

  logic            mac_clear;
  logic            mac_en;
  conv_pkg::word_t mac_result;

  win_if #(.elem_t(conv_pkg::weight_t)) wt_win ();
  win_if #(.elem_t(conv_pkg::pixel_t))  ifm_win ();

  conv_ctrl ctrl_inst (
    .clk              (clk),
    .rst              (rst),
    .xcel_start       (xcel_start),
    .xcel_done        (xcel_done),
    .xcel_idle        (xcel_idle),
    .ifm_ddr_addr     (ifm_ddr_addr),
    .wt_ddr_addr      (wt_ddr_addr),
    .ofm_ddr_addr     (ofm_ddr_addr),
    .ifm_dim          (ifm_dim),
    .read_req_valid   (read_req_valid),
    .read_req_ready   (read_req_ready),
    .read_addr        (read_addr),
    .read_data        (read_data),
    .read_data_valid  (read_data_valid),
    .read_data_ready  (read_data_ready),
    .write_req_valid  (write_req_valid),
    .write_req_ready  (write_req_ready),
    .write_addr       (write_addr),
    .write_data       (write_data),
    .write_data_valid (write_data_valid),
    .write_data_ready (write_data_ready),
    .wt_win           (wt_win.ctrl),
    .ifm_win          (ifm_win.ctrl),
    .mac_clear        (mac_clear),
    .mac_en           (mac_en),
    .mac_result       (mac_result)
  );

  window_buffer #(.elem_t(conv_pkg::weight_t)) wt_buf_inst (
    .clk (clk),
    .rst (rst),
    .win (wt_win.buffer)
  );

  window_buffer #(.elem_t(conv_pkg::pixel_t)) ifm_buf_inst (
    .clk (clk),
    .rst (rst),
    .win (ifm_win.buffer)
  );

  // both window heads meet at the multiplier
  mac_unit mac_inst (
    .clk       (clk),
    .rst       (rst),
    .mac_clear (mac_clear),
    .mac_en    (mac_en),
    .pixel     (ifm_win.head),
    .weight    (wt_win.head),
    .result    (mac_result)
  );

endmodule

// File: tb_conv_xcel.sv
`timescale 1ns/10ps

module tb_conv_xcel;

  localparam logic [31:0] IFM_BASE  = 32'h0000_1000;
  localparam logic [31:0] WT_BASE   = 32'h0000_2000;
  localparam logic [31:0] OFM_BASE  = 32'h0000_3000;
  localparam int          MEM_BYTES = 16384;
  localparam int          TIMEOUT   = 20000;

  logic            clk;
  logic            rst;
  logic            xcel_start;
  logic            xcel_done;
  logic            xcel_idle;
  conv_pkg::addr_t ifm_ddr_addr;
  conv_pkg::addr_t wt_ddr_addr;
  conv_pkg::addr_t ofm_ddr_addr;
  logic [31:0]     ifm_dim;
  logic            read_req_valid;
  logic            read_req_ready;
  conv_pkg::addr_t read_addr;
  conv_pkg::word_t read_data;
  logic            read_data_valid;
  logic            read_data_ready;
  logic            write_req_valid;
  logic            write_req_ready;
  conv_pkg::addr_t write_addr;
  conv_pkg::word_t write_data;
  logic            write_data_valid;
  logic            write_data_ready;

  logic [7:0]  mem [MEM_BYTES];
  logic [31:0] trace_q [$];
  logic [31:0] expected_q [$];
  int          dim;
  int          odim;
  int          npix;
  int          reads_per_run;
  int          rd_count;
  int          wr_req_count;
  int          wr_data_count;

  conv_xcel conv_xcel_inst (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_error(string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected)
    else report_error($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
  endtask

  task automatic check_true(logic cond, string msg);
    assert (cond)
    else report_error(msg);
  endtask

  // background bytes outside the trace regions
  function automatic logic [7:0] fill_byte(logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic logic [31:0] fetch_word(logic [31:0] addr);
    logic [31:0] base;
    base = {addr[31:2], 2'b00};
    return {mem[base+3], mem[base+2], mem[base+1], mem[base]};
  endfunction

  // kernel reads first, then one window per output pixel in raster order
  function automatic logic [31:0] expected_read_addr(int n);
    int idx, pix, k, ox, oy, wx, wy;
    idx = n % reads_per_run;
    if (idx < conv_pkg::WT_SIZE) begin
      return WT_BASE + idx;
    end
    pix = idx / conv_pkg::WT_SIZE - 1;
    k   = idx % conv_pkg::WT_SIZE;
    ox  = pix % odim;
    oy  = pix / odim;
    wx  = k % conv_pkg::WT_DIM;
    wy  = k / conv_pkg::WT_DIM;
    return IFM_BASE + (oy + wy) * dim + ox + wx;
  endfunction

  task automatic load_trace();
    int          fd;
    int          status;
    int          line_len;
    logic [31:0] value;
    string       comment;
    fd = $fopen("conv_trace.hex", "r");
    check_true(fd != 0, "could not open conv_trace.hex");
    status = 0;
    while (status != -1) begin
      status = $fscanf(fd, "%h", value);
      if (status == 1) begin
        trace_q.push_back(value);
      end else if (status == 0) begin
        // comment line
        line_len = $fgets(comment, fd);
        if (line_len == 0) begin
          status = -1;
        end
      end
    end
    $fclose(fd);
    check_true(trace_q.size() > 0, "trace file holds no values");
    dim           = trace_q[0];
    odim          = dim - (conv_pkg::WT_DIM - 1);
    npix          = odim * odim;
    reads_per_run = conv_pkg::WT_SIZE * (npix + 1);
    check_true(trace_q.size() == 1 + dim * dim + conv_pkg::WT_SIZE + npix,
               "trace file holds the wrong number of values");
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem[a] = fill_byte(a);
    end
    for (int i = 0; i < dim * dim; i++) begin
      mem[IFM_BASE + i] = trace_q[1 + i][7:0];
    end
    for (int i = 0; i < conv_pkg::WT_SIZE; i++) begin
      mem[WT_BASE + i] = trace_q[1 + dim * dim + i][7:0];
    end
    for (int i = 0; i < npix; i++) begin
      expected_q.push_back(trace_q[1 + dim * dim + conv_pkg::WT_SIZE + i]);
    end
  endtask

  task automatic wait_for_done(int run);
    int cycles;
    cycles = 0;
    while (!xcel_done && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    check_true(xcel_done, $sformatf("timed out waiting for xcel_done in run %0d", run));
  endtask

  task automatic run_conv(int run);
    @(negedge clk);
    xcel_start = 1'b1;
    #1;
    // done is masked while start is high
    check_value("xcel_done", 32'd0, xcel_done);
    @(negedge clk);
    xcel_start = 1'b0;
    #1;
    check_value("xcel_done", 32'd0, xcel_done);
    check_value("xcel_idle", 32'd0, xcel_idle);
    wait_for_done(run);
    check_true(wr_data_count == run * npix,
               $sformatf("run %0d ended after %0d writes", run, wr_data_count));
    check_true(rd_count == run * reads_per_run,
               $sformatf("run %0d ended after %0d reads", run, rd_count));
  endtask

  // memory model with random request and data delays
  initial begin : memory_model
    int          rreq_wait;
    int          rdata_wait;
    int          wreq_wait;
    int          wdata_wait;
    logic        rd_outstanding;
    logic        rreq_stalled;
    logic        wreq_stalled;
    logic [31:0] rd_word_addr;
    logic [31:0] held_read_addr;
    logic [31:0] held_write_addr;
    void'($urandom(32'hdfe));
    read_req_ready   = 1'b0;
    read_data        = '0;
    read_data_valid  = 1'b0;
    write_req_ready  = 1'b0;
    write_data_ready = 1'b0;
    rd_count         = 0;
    wr_req_count     = 0;
    wr_data_count    = 0;
    rreq_wait        = 0;
    rdata_wait       = 0;
    wreq_wait        = 0;
    wdata_wait       = 0;
    rd_outstanding   = 1'b0;
    rreq_stalled     = 1'b0;
    wreq_stalled     = 1'b0;
    rd_word_addr     = '0;
    held_read_addr   = '0;
    held_write_addr  = '0;
    forever begin
      @(negedge clk);
      if (rst) begin
        read_req_ready   = 1'b0;
        read_data_valid  = 1'b0;
        write_req_ready  = 1'b0;
        write_data_ready = 1'b0;
        rd_outstanding   = 1'b0;
        rreq_stalled     = 1'b0;
        wreq_stalled     = 1'b0;
      end else begin
        if (rreq_stalled) begin
          check_true(read_req_valid, "read request valid dropped before the request fired");
          check_value("read_addr", held_read_addr, read_addr);
        end
        if (wreq_stalled) begin
          check_true(write_req_valid, "write request valid dropped before the request fired");
          check_value("write_addr", held_write_addr, write_addr);
        end
        check_true(!(rd_outstanding && read_req_valid),
                   "second read request raised while a read was outstanding");

        read_data_valid = 1'b0;
        if (rd_outstanding) begin
          if (rdata_wait == 0) begin
            read_data_valid = 1'b1;
            read_data       = fetch_word(rd_word_addr);
            rd_outstanding  = !read_data_ready;
          end else begin
            rdata_wait--;
          end
        end

        read_req_ready = 1'b0;
        rreq_stalled   = 1'b0;
        if (read_req_valid) begin
          if (rreq_wait == 0) begin
            read_req_ready = 1'b1;
            check_true(read_addr < MEM_BYTES - 3, "read address outside the memory model");
            check_value("read_addr", expected_read_addr(rd_count), read_addr);
            rd_word_addr   = read_addr;
            rd_outstanding = 1'b1;
            rd_count++;
            rreq_wait  = $urandom % 4;
            rdata_wait = $urandom % 4;
          end else begin
            rreq_wait--;
            rreq_stalled   = 1'b1;
            held_read_addr = read_addr;
          end
        end

        write_req_ready = 1'b0;
        wreq_stalled    = 1'b0;
        if (write_req_valid) begin
          if (wreq_wait == 0) begin
            write_req_ready = 1'b1;
            // raster index equals oy*ofm_dim+ox
            check_value("write_addr",
                        OFM_BASE + conv_pkg::OFM_BYTES * (wr_req_count % npix), write_addr);
            wr_req_count++;
            wreq_wait = $urandom % 4;
          end else begin
            wreq_wait--;
            wreq_stalled    = 1'b1;
            held_write_addr = write_addr;
          end
        end

        write_data_ready = 1'b0;
        if (write_data_valid) begin
          if (wdata_wait == 0) begin
            write_data_ready = 1'b1;
            check_value("write_data", expected_q[wr_data_count % npix], write_data);
            wr_data_count++;
            wdata_wait = $urandom % 4;
          end else begin
            wdata_wait--;
          end
        end
      end
    end
  end

  initial begin : stimulus
    rst          = 1'b1;
    xcel_start   = 1'b0;
    ifm_ddr_addr = IFM_BASE;
    wt_ddr_addr  = WT_BASE;
    ofm_ddr_addr = OFM_BASE;
    ifm_dim      = 32'd0;
    load_trace();
    ifm_dim = dim;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("xcel_idle", 32'd1, xcel_idle);
    check_value("xcel_done", 32'd0, xcel_done);
    check_value("read_req_valid", 32'd0, read_req_valid);
    check_value("read_data_ready", 32'd0, read_data_ready);
    check_value("write_req_valid", 32'd0, write_req_valid);
    check_value("write_data_valid", 32'd0, write_data_valid);
    run_conv(1);
    // done holds while start stays low
    repeat (5) begin
      @(negedge clk);
      check_value("xcel_done", 32'd1, xcel_done);
      check_value("xcel_idle", 32'd1, xcel_idle);
    end
    run_conv(2);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: conv_trace.hex
// ifm_dim, then the ifm bytes in raster order, then the kernel bytes row by row,
// then the expected output words in raster order
// ifm_dim
08
// ifm pixel (x,y) = 16x - 8y - 50
CE DE EE FE 0E 1E 2E 3E
C6 D6 E6 F6 06 16 26 36
BE CE DE EE FE 0E 1E 2E
B6 C6 D6 E6 F6 06 16 26
AE BE CE DE EE FE 0E 1E
A6 B6 C6 D6 E6 F6 06 16
9E AE BE CE DE EE FE 0E
96 A6 B6 C6 D6 E6 F6 06
// kernel weight (wx,wy) = 3wx - 2wy + 1
01 04 07 0A 0D
FF 02 05 08 0B
FD 00 03 06 09
FB FE 01 04 07
F9 FC FF 02 05
// expected words, sum 1200ox - 600oy + 650 shifted right by 9
00000001 00000003 00000005 00000008
00000000 00000002 00000004 00000007
FFFFFFFE 00000001 00000003 00000005
FFFFFFFD 00000000 00000002 00000004

// File: tb.f
conv_pkg.sv
win_if.sv
window_buffer.sv
mac_unit.sv
conv_ctrl.sv
conv_xcel.sv
tb_conv_xcel.sv

// File: Bender.yml
package:
  name: conv_xcel

sources:
  - conv_pkg.sv
  - win_if.sv
  - window_buffer.sv
  - mac_unit.sv
  - conv_ctrl.sv
  - conv_xcel.sv
  - target: test
    files:
      - tb_conv_xcel.sv
